/* rtl/cpu_pkg.sv */
package cpu_pkg;

  localparam int word_w     = 16;
  localparam int ram_aw     = 10;
  localparam int page_off_w = 6;                     // 64-word pages
  localparam int page_idx_w = 4;
  localparam int num_pages  = 1 << page_idx_w;
  localparam int lpage_w    = word_w - page_off_w;   // upper bits of a logical address
  localparam int reg_idx_w  = 3;
  localparam int num_regs   = 1 << reg_idx_w;
  localparam int axi_aw     = 8;
  localparam int axi_dw     = 32;

  localparam logic [7:0] op_jmp       = 8'd1;
  localparam logic [7:0] op_ram2reg   = 8'd2;
  localparam logic [7:0] op_reg2ram   = 8'd3;
  localparam logic [7:0] op_num2reg   = 8'd4;
  localparam logic [7:0] op_reg_plus  = 8'd5;
  localparam logic [7:0] op_reg_minus = 8'd6;
  localparam logic [7:0] op_exit      = 8'd17;

  typedef struct packed {
    logic                  used;
    logic [page_idx_w-1:0] next;    // 0 marks the chain end
    logic [lpage_w-1:0]    lpage;
  } page_entry_t;

  localparam logic [axi_aw-1:0] addr_ctrl      = 8'h00;
  localparam logic [axi_aw-1:0] addr_status    = 8'h04;
  localparam logic [axi_aw-1:0] addr_load_addr = 8'h08;
  localparam logic [axi_aw-1:0] addr_load_data = 8'h0C;
  localparam logic [axi_aw-1:0] addr_reg_base  = 8'h20;   // 4 bytes per register

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

/* rtl/mmu_if.sv */
`timescale 1ns/1ps

interface mmu_if;

  logic                       req;
  logic                       we;
  logic [cpu_pkg::word_w-1:0] laddr;   // logical word address
  logic [cpu_pkg::word_w-1:0] wdata;
  logic                       ack;     // one-cycle pulse
  logic [cpu_pkg::word_w-1:0] rdata;
  logic                       fault;   // sticky, no free page left

  modport core (
    output req, we, laddr, wdata,
    input  ack, rdata, fault
  );

  modport mmu (
    input  req, we, laddr, wdata,
    output ack, rdata, fault
  );

endinterface

/* rtl/ram_sdp.sv */
`timescale 1ns/1ps

module ram_sdp #(
  parameter int  depth  = 1024,
  parameter type word_t = logic [15:0]
) (
  input  logic                     clka,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] waddr,
  input  word_t                    wdata,
  input  logic                     re,
  input  logic [$clog2(depth)-1:0] raddr,
  output word_t                    rdata
);

  word_t mem [depth];

  always_ff @(posedge clka) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    if (re) begin
      rdata <= mem[raddr];   // old data on a same-address write
    end
  end

  a_waddr_known: assert property (@(posedge clka) we |-> !$isunknown(waddr))
    else $error("ram write with unknown address");

endmodule

/* rtl/page_mmu.sv */
`timescale 1ns/1ps

module page_mmu (
  input  logic                       clka,
  input  logic                       rst,
  mmu_if.mmu                         bus,
  input  logic                       load_valid,
  input  logic [cpu_pkg::ram_aw-1:0] load_addr,
  input  logic [cpu_pkg::word_w-1:0] load_data,
  output logic                       fault
);

  typedef enum logic [3:0] {
    s_init, s_mark, s_idle, s_walk_rd, s_walk_chk, s_scan_rd, s_scan_chk,
    s_link, s_access, s_ack, s_fault
  } state_t;

  state_t                           state;
  logic [cpu_pkg::page_idx_w-1:0]   cur_idx;      // walk position, init counter
  logic [cpu_pkg::page_idx_w-1:0]   scan_idx;
  cpu_pkg::page_entry_t             tail_entry;
  logic [cpu_pkg::lpage_w-1:0]      last_lpage;   // last translation
  logic [cpu_pkg::page_idx_w-1:0]   last_phys;
  logic [cpu_pkg::lpage_w-1:0]      req_lpage;
  logic [cpu_pkg::ram_aw-1:0]       phys_addr;

  logic                             pt_we;
  logic                             pt_re;
  logic [cpu_pkg::page_idx_w-1:0]   pt_waddr;
  logic [cpu_pkg::page_idx_w-1:0]   pt_raddr;
  cpu_pkg::page_entry_t             pt_wdata;
  cpu_pkg::page_entry_t             pt_rdata;
  logic                             ram_we;
  logic                             ram_re;
  logic [cpu_pkg::ram_aw-1:0]       ram_waddr;
  logic [cpu_pkg::word_w-1:0]       ram_wdata;
  logic [cpu_pkg::word_w-1:0]       ram_rdata;

  assign req_lpage = bus.laddr[cpu_pkg::word_w-1:cpu_pkg::page_off_w];
  assign phys_addr = {last_phys, bus.laddr[cpu_pkg::page_off_w-1:0]};

  assign pt_re    = (state == s_walk_rd) || (state == s_scan_rd);
  assign pt_raddr = (state == s_scan_rd) ? scan_idx : cur_idx;

  always_comb begin
    pt_we    = 1'b0;
    pt_waddr = cur_idx;
    pt_wdata = '0;
    case (state)
      s_init: pt_we = 1'b1;              // clear entry
      s_mark: begin
        pt_we         = 1'b1;
        pt_waddr      = '0;
        pt_wdata.used = 1'b1;            // page 0, logical page 0, chain end
      end
      s_scan_chk: if (!pt_rdata.used) begin
        pt_we          = 1'b1;
        pt_waddr       = scan_idx;
        pt_wdata.used  = 1'b1;
        pt_wdata.lpage = req_lpage;      // new chain end
      end
      s_link: begin
        pt_we         = 1'b1;            // cur_idx still holds the old tail
        pt_wdata      = tail_entry;
        pt_wdata.next = scan_idx;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state      <= s_init;
      cur_idx    <= '0;
      last_lpage <= '0;
      last_phys  <= '0;
    end else begin
      case (state)
        s_init: begin
          cur_idx <= cur_idx + 1'b1;
          if (&cur_idx) begin
            state <= s_mark;
          end
        end
        s_mark: state <= s_idle;
        s_idle: if (bus.req) begin
          if (req_lpage == last_lpage) begin
            state <= s_access;
          end else begin
            cur_idx <= '0;               // walk from segment 0
            state   <= s_walk_rd;
          end
        end
        s_walk_rd: state <= s_walk_chk;
        s_walk_chk: begin
          if (pt_rdata.lpage == req_lpage) begin
            last_lpage <= req_lpage;
            last_phys  <= cur_idx;
            state      <= s_access;
          end else if (pt_rdata.next == '0) begin
            tail_entry <= pt_rdata;
            scan_idx   <= cpu_pkg::page_idx_w'(1);
            state      <= s_scan_rd;
          end else begin
            cur_idx <= pt_rdata.next;
            state   <= s_walk_rd;
          end
        end
        s_scan_rd: state <= s_scan_chk;
        s_scan_chk: begin
          if (!pt_rdata.used) begin
            state <= s_link;
          end else if (&scan_idx) begin
            state <= s_fault;            // table full
          end else begin
            scan_idx <= scan_idx + 1'b1;
            state    <= s_scan_rd;
          end
        end
        s_link: begin
          last_lpage <= req_lpage;
          last_phys  <= scan_idx;
          state      <= s_access;
        end
        s_access: state <= s_ack;
        s_ack:    state <= s_idle;
        s_fault:  state <= s_fault;
        default:  state <= s_init;
      endcase
    end
  end

  assign ram_we    = load_valid || (state == s_access && bus.we);   // host load wins
  assign ram_waddr = load_valid ? load_addr : phys_addr;
  assign ram_wdata = load_valid ? load_data : bus.wdata;
  assign ram_re    = (state == s_access) && !bus.we;

  assign bus.ack   = (state == s_ack);
  assign bus.rdata = ram_rdata;
  assign fault     = (state == s_fault);
  assign bus.fault = fault;

  ram_sdp #(
    .depth (1 << cpu_pkg::ram_aw),
    .word_t(logic [cpu_pkg::word_w-1:0])
  ) main_ram (
    .clka (clka),
    .we   (ram_we),
    .waddr(ram_waddr),
    .wdata(ram_wdata),
    .re   (ram_re),
    .raddr(phys_addr),
    .rdata(ram_rdata)
  );

  ram_sdp #(
    .depth (cpu_pkg::num_pages),
    .word_t(cpu_pkg::page_entry_t)
  ) page_table (
    .clka (clka),
    .we   (pt_we),
    .waddr(pt_waddr),
    .wdata(pt_wdata),
    .re   (pt_re),
    .raddr(pt_raddr),
    .rdata(pt_rdata)
  );

  a_ack_needs_req: assert property (@(posedge clka) disable iff (!rst) bus.ack |-> bus.req)
    else $error("mmu ack without a pending request");

  a_walk_used: assert property (@(posedge clka) disable iff (!rst)
    state == s_walk_chk |-> pt_rdata.used)
    else $error("page walk reached an unused entry");

endmodule

/* rtl/core_seq.sv */
`timescale 1ns/1ps

module core_seq (
  input  logic                          clka,
  input  logic                          rst,
  input  logic                          run,
  output logic                          halted,
  output logic                          running,
  input  logic [cpu_pkg::reg_idx_w-1:0] reg_rd_idx,
  output logic [cpu_pkg::word_w-1:0]    reg_rd_data,
  mmu_if.core                           mem
);

  typedef enum logic [2:0] {
    c_idle, c_fetch0, c_fetch1, c_exec, c_data, c_halt
  } state_t;

  state_t                        state;
  logic [cpu_pkg::word_w-1:0]    pc;
  logic [cpu_pkg::word_w-1:0]    regs [cpu_pkg::num_regs];
  logic [7:0]                    inst_op;
  logic [cpu_pkg::reg_idx_w-1:0] inst_reg;
  logic [cpu_pkg::word_w-1:0]    inst_arg;    // operand word

  assign mem.req     = (state == c_fetch0) || (state == c_fetch1) || (state == c_data);
  assign mem.we      = (state == c_data) && (inst_op == cpu_pkg::op_reg2ram);
  assign mem.wdata   = regs[inst_reg];
  assign halted      = (state == c_halt);
  assign running     = (state != c_idle) && (state != c_halt);
  assign reg_rd_data = regs[reg_rd_idx];

  always_comb begin
    case (state)
      c_fetch1: mem.laddr = pc + 1'b1;
      c_data:   mem.laddr = inst_arg;
      default:  mem.laddr = pc;
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= c_idle;
      pc    <= '0;
      for (int i = 0; i < cpu_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (state)
        c_idle: if (run) begin
          state <= c_fetch0;
        end
        c_fetch0: begin
          if (mem.fault) begin
            state <= c_halt;
          end else if (mem.ack) begin
            inst_op  <= mem.rdata[cpu_pkg::word_w-1 -: 8];   // opcode in high byte
            inst_reg <= mem.rdata[cpu_pkg::reg_idx_w-1:0];
            state    <= c_fetch1;
          end
        end
        c_fetch1: begin
          if (mem.fault) begin
            state <= c_halt;
          end else if (mem.ack) begin
            inst_arg <= mem.rdata;
            state    <= c_exec;
          end
        end
        c_exec: begin
          pc    <= pc + 16'd2;
          state <= c_fetch0;
          case (inst_op)
            cpu_pkg::op_jmp:       pc <= inst_arg;
            cpu_pkg::op_num2reg:   regs[inst_reg] <= inst_arg;
            cpu_pkg::op_reg_plus:  regs[inst_reg] <= regs[inst_reg] + inst_arg;
            cpu_pkg::op_reg_minus: regs[inst_reg] <= regs[inst_reg] - inst_arg;
            cpu_pkg::op_ram2reg,
            cpu_pkg::op_reg2ram:   state <= c_data;
            cpu_pkg::op_exit:      state <= c_halt;
            default: ;             // no-op
          endcase
        end
        c_data: begin
          if (mem.fault) begin
            state <= c_halt;
          end else if (mem.ack) begin
            if (inst_op == cpu_pkg::op_ram2reg) begin
              regs[inst_reg] <= mem.rdata;
            end
            state <= c_fetch0;
          end
        end
        c_halt:  state <= c_halt;   // left only by reset
        default: state <= c_idle;
      endcase
    end
  end

  a_req_stable: assert property (@(posedge clka) disable iff (!rst)
    mem.req && !mem.ack && !mem.fault |=>
      mem.req && $stable(mem.laddr) && $stable(mem.we) && $stable(mem.wdata))
    else $error("memory request changed before ack");

endmodule

/* rtl/host_regs.sv */
`timescale 1ns/1ps

module host_regs (
  input  logic                          clka,
  input  logic                          rst,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [cpu_pkg::axi_aw-1:0]    awaddr,
  input  logic                          wvalid,
  output logic                          wready,
  input  logic [cpu_pkg::axi_dw-1:0]    wdata,
  output logic                          bvalid,
  input  logic                          bready,
  output logic [1:0]                    bresp,
  input  logic                          arvalid,
  output logic                          arready,
  input  logic [cpu_pkg::axi_aw-1:0]    araddr,
  output logic                          rvalid,
  input  logic                          rready,
  output logic [cpu_pkg::axi_dw-1:0]    rdata,
  output logic [1:0]                    rresp,
  output logic                          run,
  input  logic                          halted,
  input  logic                          running,
  input  logic                          fault,
  output logic [cpu_pkg::reg_idx_w-1:0] reg_rd_idx,
  input  logic [cpu_pkg::word_w-1:0]    reg_rd_data,
  output logic                          load_valid,
  output logic [cpu_pkg::ram_aw-1:0]    load_addr,
  output logic [cpu_pkg::word_w-1:0]    load_data
);

  localparam int win_lsb = cpu_pkg::reg_idx_w + 2;   // register window select bits

  logic                       wr_go;
  logic                       rd_go;
  logic                       reg_hit;
  logic [cpu_pkg::ram_aw-1:0] load_ptr;

  assign wr_go      = awvalid && wvalid && !bvalid;   // aw and w taken together
  assign awready    = wr_go;
  assign wready     = wr_go;
  assign bresp      = cpu_pkg::resp_okay;
  assign rd_go      = arvalid && !rvalid;
  assign arready    = rd_go;
  assign reg_rd_idx = araddr[2 +: cpu_pkg::reg_idx_w];
  assign reg_hit    = (araddr[cpu_pkg::axi_aw-1:win_lsb] ==
                       cpu_pkg::addr_reg_base[cpu_pkg::axi_aw-1:win_lsb]) &&
                      (araddr[1:0] == 2'b00);

  always_ff @(posedge clka) begin
    if (!rst) begin
      bvalid     <= 1'b0;
      run        <= 1'b0;
      load_valid <= 1'b0;
      load_ptr   <= '0;
    end else begin
      load_valid <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wr_go) begin
        bvalid <= 1'b1;
        case (awaddr)
          cpu_pkg::addr_ctrl: if (wdata[0]) begin
            run <= 1'b1;                                   // one start per reset
          end
          cpu_pkg::addr_load_addr: if (!run) begin
            load_ptr <= wdata[cpu_pkg::ram_aw-1:0];
          end
          cpu_pkg::addr_load_data: if (!run) begin
            load_valid <= 1'b1;
            load_addr  <= load_ptr;
            load_data  <= wdata[cpu_pkg::word_w-1:0];
            load_ptr   <= load_ptr + 1'b1;                 // auto increment
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      rvalid <= 1'b0;
    end else begin
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (rd_go) begin
        rvalid <= 1'b1;
        rresp  <= cpu_pkg::resp_okay;
        rdata  <= '0;
        if (reg_hit) begin
          rdata[cpu_pkg::word_w-1:0] <= reg_rd_data;
        end else begin
          case (araddr)
            cpu_pkg::addr_ctrl:      rdata[0] <= run;
            cpu_pkg::addr_status:    rdata[2:0] <= {running, fault, halted};
            cpu_pkg::addr_load_addr: rdata[cpu_pkg::ram_aw-1:0] <= load_ptr;
            cpu_pkg::addr_load_data: ;                     // write only, reads 0
            default:                 rresp <= cpu_pkg::resp_slverr;
          endcase
        end
      end
    end
  end

  a_bvalid_hold: assert property (@(posedge clka) disable iff (!rst)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
  input  logic                       clka,
  input  logic                       rst,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [cpu_pkg::axi_aw-1:0] awaddr,
  input  logic                       wvalid,
  output logic                       wready,
  input  logic [cpu_pkg::axi_dw-1:0] wdata,
  output logic                       bvalid,
  input  logic                       bready,
  output logic [1:0]                 bresp,
  input  logic                       arvalid,
  output logic                       arready,
  input  logic [cpu_pkg::axi_aw-1:0] araddr,
  output logic                       rvalid,
  input  logic                       rready,
  output logic [cpu_pkg::axi_dw-1:0] rdata,
  output logic [1:0]                 rresp
);

  logic                          run;
  logic                          halted;
  logic                          running;
  logic                          fault;
  logic [cpu_pkg::reg_idx_w-1:0] reg_rd_idx;
  logic [cpu_pkg::word_w-1:0]    reg_rd_data;
  logic                          load_valid;
  logic [cpu_pkg::ram_aw-1:0]    load_addr;
  logic [cpu_pkg::word_w-1:0]    load_data;

  mmu_if mem_bus ();

  host_regs u_host_regs (
    .clka       (clka),
    .rst        (rst),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .run        (run),
    .halted     (halted),
    .running    (running),
    .fault      (fault),
    .reg_rd_idx (reg_rd_idx),
    .reg_rd_data(reg_rd_data),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  core_seq u_core_seq (
    .clka       (clka),
    .rst        (rst),
    .run        (run),
    .halted     (halted),
    .running    (running),
    .reg_rd_idx (reg_rd_idx),
    .reg_rd_data(reg_rd_data),
    .mem        (mem_bus.core)
  );

  page_mmu u_page_mmu (
    .clka      (clka),
    .rst       (rst),
    .bus       (mem_bus.mmu),
    .load_valid(load_valid),
    .load_addr (load_addr),
    .load_data (load_data),
    .fault     (fault)
  );

endmodule

/* dv/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

  localparam int drive_dly   = 10;                  // ns after the rising edge
  localparam int cycle_limit = 6 * 40 * 80 + 800;   // programs x instructions x worst cycles

  logic        clka;
  logic        rst;
  logic        awvalid;
  logic        awready;
  logic [7:0]  awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [7:0]  araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  int          mismatches = 0;
  int          failures   = 0;
  int          cycles     = 0;
  integer      seed;
  logic [15:0] model [8];    // expected register file
  logic [15:0] prog  [$];    // program words, loaded from address 0

  cpu_top uut (.*);

  initial clka = 1'b0;
  always #50 clka = ~clka;

  always @(posedge clka) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  a_bvalid_hold: assert property (@(posedge clka) disable iff (!rst)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      failures++;
      $display("write response dropped before bready");
    end

  a_rvalid_hold: assert property (@(posedge clka) disable iff (!rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      failures++;
      $display("read data changed or dropped before rready");
    end

  a_bvalid_cause: assert property (@(posedge clka) disable iff (!rst)
    $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
    else begin
      failures++;
      $display("write response without an accepted write");
    end

  a_rvalid_cause: assert property (@(posedge clka) disable iff (!rst)
    $rose(rvalid) |-> $past(arvalid && arready))
    else begin
      failures++;
      $display("read data without an accepted read address");
    end

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (actual === expected) else begin
      mismatches++;
      $display("mismatch %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic write_axi(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clka);
    #drive_dly;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    do begin
      @(posedge clka);
    end while (!(awready && wready));
    #drive_dly;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(posedge clka);      // bready low for one cycle
    #drive_dly;
    bready = 1'b1;
    do begin
      @(posedge clka);
    end while (!bvalid);
    check_eq("bresp", 32'(cpu_pkg::resp_okay), 32'(bresp));
    #drive_dly;
    bready = 1'b0;
  endtask

  task automatic read_axi(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clka);
    #drive_dly;
    arvalid = 1'b1;
    araddr  = addr;
    do begin
      @(posedge clka);
    end while (!arready);
    #drive_dly;
    arvalid = 1'b0;
    @(posedge clka);      // rready low for one cycle
    #drive_dly;
    rready = 1'b1;
    do begin
      @(posedge clka);
    end while (!rvalid);
    data = rdata;
    resp = rresp;
    #drive_dly;
    rready = 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clka);
    #drive_dly;
    rst = 1'b0;
    repeat (2) @(posedge clka);
    #drive_dly;
    rst = 1'b1;
    prog.delete();
    for (int i = 0; i < 8; i++) begin
      model[i] = '0;
    end
  endtask

  task automatic add_inst(input logic [7:0] op, input logic [2:0] r, input logic [15:0] arg);
    prog.push_back({op, 5'd0, r});   // opcode high byte, register low byte
    prog.push_back(arg);
  endtask

  task automatic load_program();
    write_axi(cpu_pkg::addr_load_addr, 32'd0);
    foreach (prog[i]) begin
      write_axi(cpu_pkg::addr_load_data, {16'd0, prog[i]});
    end
  endtask

  task automatic wait_halt(output logic [31:0] status);
    logic [1:0] resp;
    status = '0;
    while (!status[0]) begin
      read_axi(cpu_pkg::addr_status, status, resp);
    end
  endtask

  task automatic run_program(output logic [31:0] status);
    load_program();
    write_axi(cpu_pkg::addr_ctrl, 32'd1);
    wait_halt(status);
  endtask

  task automatic check_regs();
    logic [31:0] data;
    logic [1:0]  resp;
    for (int i = 0; i < 8; i++) begin
      read_axi(cpu_pkg::addr_reg_base + 8'(4 * i), data, resp);
      check_eq("rresp", 32'(cpu_pkg::resp_okay), 32'(resp));
      check_eq($sformatf("r%0d", i), {16'd0, model[i]}, data);
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] data;
    logic [31:0] status;
    logic [1:0]  resp;
    logic [15:0] addrs [4];
    seed    = 32'he5b8;
    rst     = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;

    apply_reset();    // idle state after reset
    check_eq("bvalid", 32'd0, 32'(bvalid));
    check_eq("rvalid", 32'd0, 32'(rvalid));
    read_axi(cpu_pkg::addr_status, data, resp);
    check_eq("status", 32'd0, data);
    check_regs();

    apply_reset();    // random arithmetic
    for (int i = 0; i < 30; i++) begin
      rnd = next_rand();
      case (rnd[5:4])
        2'd0: begin
          add_inst(cpu_pkg::op_num2reg, rnd[2:0], rnd[31:16]);
          model[rnd[2:0]] = rnd[31:16];
        end
        2'd1: begin
          add_inst(cpu_pkg::op_reg_plus, rnd[2:0], rnd[31:16]);
          model[rnd[2:0]] = model[rnd[2:0]] + rnd[31:16];
        end
        default: begin
          add_inst(cpu_pkg::op_reg_minus, rnd[2:0], rnd[31:16]);
          model[rnd[2:0]] = model[rnd[2:0]] - rnd[31:16];
        end
      endcase
    end
    add_inst(cpu_pkg::op_exit, 3'd0, 16'd0);
    run_program(status);
    check_eq("status", 32'd1, status);
    check_regs();

    apply_reset();    // forward jump over two loads
    rnd = next_rand();
    add_inst(cpu_pkg::op_num2reg, 3'd0, rnd[15:0]);
    add_inst(cpu_pkg::op_jmp, 3'd0, 16'd8);            // word address of instruction 4
    add_inst(cpu_pkg::op_num2reg, 3'd1, rnd[31:16]);
    add_inst(cpu_pkg::op_num2reg, 3'd2, rnd[31:16]);
    add_inst(cpu_pkg::op_num2reg, 3'd3, rnd[31:16]);   // jump target
    add_inst(cpu_pkg::op_reg_plus, 3'd0, 16'd5);
    add_inst(cpu_pkg::op_exit, 3'd0, 16'd0);
    model[0] = rnd[15:0] + 16'd5;
    model[3] = rnd[31:16];
    run_program(status);
    check_eq("status", 32'd1, status);
    check_regs();

    apply_reset();    // data round trip over four logical pages
    addrs = '{16'h003C, 16'h0105, 16'h2A3F, 16'hFFC7};
    for (int i = 0; i < 4; i++) begin
      rnd = next_rand();
      add_inst(cpu_pkg::op_num2reg, 3'(i), rnd[15:0]);
      model[i] = rnd[15:0];
    end
    for (int i = 0; i < 4; i++) begin
      add_inst(cpu_pkg::op_reg2ram, 3'(i), addrs[i]);
    end
    for (int i = 0; i < 4; i++) begin
      add_inst(cpu_pkg::op_ram2reg, 3'(4 + i), addrs[3 - i]);   // reverse order
      model[4 + i] = model[3 - i];
    end
    add_inst(cpu_pkg::op_exit, 3'd0, 16'd0);
    run_program(status);
    check_eq("status", 32'd1, status);
    check_regs();

    apply_reset();    // page exhaustion
    rnd = next_rand();
    add_inst(cpu_pkg::op_num2reg, 3'd1, rnd[15:0]);
    model[1] = rnd[15:0];
    for (int p = 1; p <= 16; p++) begin
      add_inst(cpu_pkg::op_reg2ram, 3'd1, {10'(p), 6'(p)});   // a new logical page each
    end
    add_inst(cpu_pkg::op_num2reg, 3'd2, rnd[31:16]);          // must not execute
    add_inst(cpu_pkg::op_exit, 3'd0, 16'd0);
    run_program(status);
    check_eq("status", 32'd3, status);
    check_regs();

    apply_reset();    // bus errors and the load lock
    read_axi(8'h10, data, resp);
    check_eq("rresp", 32'(cpu_pkg::resp_slverr), 32'(resp));
    read_axi(8'h44, data, resp);
    check_eq("rresp", 32'(cpu_pkg::resp_slverr), 32'(resp));
    write_axi(8'h14, 32'hFFFF_FFFF);
    rnd = next_rand();
    add_inst(cpu_pkg::op_num2reg, 3'd0, rnd[15:0]);
    add_inst(cpu_pkg::op_num2reg, 3'd1, rnd[31:16]);
    add_inst(cpu_pkg::op_reg_plus, 3'd0, 16'h1234);
    add_inst(cpu_pkg::op_exit, 3'd0, 16'd0);
    model[0] = rnd[15:0] + 16'h1234;
    model[1] = rnd[31:16];
    load_program();
    write_axi(cpu_pkg::addr_load_addr, 32'd3);        // operand of the second load
    write_axi(cpu_pkg::addr_ctrl, 32'd1);
    write_axi(cpu_pkg::addr_load_data, {16'd0, ~rnd[31:16]});
    wait_halt(status);
    check_eq("status", 32'd1, status);
    check_regs();

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
rtl/cpu_pkg.sv
rtl/mmu_if.sv
rtl/ram_sdp.sv
rtl/page_mmu.sv
rtl/core_seq.sv
rtl/host_regs.sv
rtl/cpu_top.sv
dv/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the pass line

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module cpu_tb -f sources.f -o cpu_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/cpu_sim > "$log" 2>&1; then
  cat "$log"
  echo "simulation exited with an error"
  exit 1
fi
cat "$log"

if grep -qx "TEST OK" "$log"; then
  exit 0
fi
exit 1
